// File: vlog.f
+incdir+source
+incdir+test
source/fir_types_pkg.sv
source/fir_bus_pkg.sv
source/fir_regs.sv
source/fir_coef_bank.sv
source/fir_sample_buffer.sv
source/fir_tap_sequencer.sv
source/fir_mac.sv
source/fir_top.sv
test/tb_fir.sv

// File: Bender.yml
package:
  name: fir_stream

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/fir_types_pkg.sv
      - source/fir_bus_pkg.sv
      - source/fir_regs.sv
      - source/fir_coef_bank.sv
      - source/fir_sample_buffer.sv
      - source/fir_tap_sequencer.sv
      - source/fir_mac.sv
      - source/fir_top.sv
  - target: test
    include_dirs:
      - source
      - test
    files:
      - test/tb_fir.sv

// File: test/tb_fir_ref.svh
`ifndef TB_FIR_REF_SVH
`define TB_FIR_REF_SVH

localparam int          num_samples  = 40;        // per run, also the data_length value
localparam logic [31:0] rng_seed     = 32'h85a0;
localparam int          bus_timeout  = 8;         // cycles for a read response
localparam int          beat_timeout = 400;       // cycles for one input handshake
localparam int          run_timeout  = 4000;      // cycles for all beats of a run

// expected control words
localparam logic [31:0] status_idle  = 32'h0000_0004;  // ap_idle only
localparam logic [31:0] status_done  = 32'h0000_0002;  // ap_done only
localparam logic [31:0] status_busy  = 32'h0000_0011;  // ap_start and ss_tready before any sample

typedef logic [`FIR_DATA_W-1:0] coef_arr_t [`FIR_NUM_TAPS];
typedef logic [`FIR_DATA_W-1:0] samp_arr_t [num_samples];

// 32-bit xorshift with shifts 13 / 17 / 5
function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] v;
    v = s;
    v = v ^ (v << 13);
    v = v ^ (v >> 17);
    v = v ^ (v << 5);
    return v;
endfunction

// direct form y[n] = sum of h[i] * x[n-i]
// samples before the run count as zero and all sums wrap mod 2^32
function automatic samp_arr_t fir_reference(input coef_arr_t h, input samp_arr_t x);
    samp_arr_t   y;
    logic [31:0] acc;
    for (int n = 0; n < num_samples; n++) begin
        acc = '0;
        for (int i = 0; i < `FIR_NUM_TAPS; i++) begin
            if (n - i >= 0)
                acc = acc + h[i] * x[n - i];   // 32-bit context wraps
        end
        y[n] = acc;
    end
    return y;
endfunction

`endif

// File: test/tb_fir.sv
`timescale 1ns/100ps
`default_nettype none

`include "fir_params.svh"

module tb_fir;
    import fir_types_pkg::*;
    import fir_bus_pkg::*;

    `include "tb_fir_ref.svh"

    logic         axis_clk = 1'b0;
    logic         axis_rst_n;
    bus_req_t     bus_req;
    bus_rsp_t     bus_rsp;
    stream_beat_t ss_in, sm_out;
    logic         ss_tready, sm_tready;

    coef_arr_t    coef_h;          // coefficients loaded into the DUT
    samp_arr_t    samp_x, exp_y;   // stimulus and expected outputs of the current run
    logic [31:0]  rng_state;       // stimulus generator
    logic [31:0]  sink_rng;        // separate state for the sink
    logic         ready_random;    // sink stalls at random when set
    int           out_cnt;         // beats taken by the sink this run
    int           value_errs, proto_errs, timeout_errs;
    stream_beat_t prev_beat;
    logic         prev_stall;

    fir_top dut_i (
        .axis_clk, .axis_rst_n, .bus_req, .bus_rsp,
        .ss_in, .ss_tready, .sm_out, .sm_tready
    );

    always #4 axis_clk = ~axis_clk;   // 8 ns period

    // sink is always ready or flips a coin per cycle
    always @(posedge axis_clk) begin
        if (axis_rst_n) begin
            if (ready_random) begin
                sink_rng = xorshift32(sink_rng);
                sm_tready <= sink_rng[0];
            end else begin
                sm_tready <= 1'b1;
            end
        end
    end

    // compare process samples the handshake mid-cycle where all is settled
    always @(negedge axis_clk) begin
        if (axis_rst_n) begin
            if (prev_stall) begin
                assert (sm_out == prev_beat) else begin
                    proto_errs++;
                    $display("ERROR %0t: output beat changed while stalled", $time);
                end
            end
            if (sm_out.tvalid && sm_tready) begin   // moves on the coming edge
                assert (out_cnt < num_samples) else begin
                    proto_errs++;
                    $display("ERROR %0t: extra output beat past data_length", $time);
                end
                if (out_cnt < num_samples) begin
                    assert (sm_out.tdata == exp_y[out_cnt]) else begin
                        value_errs++;
                        $display("ERROR %0t: beat %0d data %h, expected %h",
                                 $time, out_cnt, sm_out.tdata, exp_y[out_cnt]);
                    end
                    assert (sm_out.tlast == (out_cnt == num_samples - 1)) else begin
                        value_errs++;
                        $display("ERROR %0t: beat %0d tlast %b", $time, out_cnt, sm_out.tlast);
                    end
                end
                out_cnt++;
            end
            prev_stall = sm_out.tvalid && !sm_tready;
            prev_beat  = sm_out;
        end
    end

    function automatic logic [31:0] next_random();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    function automatic logic [`FIR_ADDR_W-1:0] tap_addr(input int i);
        return `FIR_ADDR_W'(`FIR_REG_TAP_BASE + 4 * i);   // h[i] at base + 4i
    endfunction

    task automatic bus_write(input logic [`FIR_ADDR_W-1:0] addr, input logic [31:0] data);
        @(posedge axis_clk);
        bus_req <= '{wr_stb: 1'b1, rd_stb: 1'b0, addr: addr, wdata: data};
        @(posedge axis_clk);
        bus_req <= '0;   // single-cycle strobe
    endtask

    task automatic bus_read(input logic [`FIR_ADDR_W-1:0] addr, output logic [31:0] data);
        bit got;
        got  = 1'b0;
        data = 'x;
        @(posedge axis_clk);
        bus_req <= '{wr_stb: 1'b0, rd_stb: 1'b1, addr: addr, wdata: '0};
        @(posedge axis_clk);
        bus_req <= '0;
        for (int t = 0; t < bus_timeout && !got; t++) begin
            @(negedge axis_clk);
            if (bus_rsp.rd_valid) begin
                data = bus_rsp.rd_data;
                got  = 1'b1;
            end
        end
        if (!got) begin
            timeout_errs++;
            $display("timeout: no read response from address %h", addr);
        end
    endtask

    task automatic check_read(input logic [`FIR_ADDR_W-1:0] addr, input logic [31:0] expected,
                              input string what);
        logic [31:0] data;
        bus_read(addr, data);
        assert (data === expected) else begin
            value_errs++;
            $display("ERROR %0t: %s read %h, expected %h", $time, what, data, expected);
        end
    endtask

    task automatic load_coefs();
        for (int i = 0; i < `FIR_NUM_TAPS; i++) begin
            coef_h[i] = next_random();
            bus_write(tap_addr(i), coef_h[i]);
        end
    endtask

    task automatic send_samples(input samp_arr_t x);
        bit taken;
        for (int n = 0; n < num_samples; n++) begin
            @(posedge axis_clk);   // also the transfer edge of the previous beat
            ss_in <= '{tvalid: 1'b1, tdata: x[n], tlast: 1'b0};
            taken = 1'b0;
            for (int t = 0; t < beat_timeout && !taken; t++) begin
                @(negedge axis_clk);
                taken = ss_tready;
            end
            if (!taken) begin
                timeout_errs++;
                $display("timeout: input sample %0d was never accepted", n);
                break;
            end
        end
        @(posedge axis_clk);
        ss_in <= '0;
    endtask

    task automatic wait_outputs();
        bit done;
        done = 1'b0;
        for (int t = 0; t < run_timeout && !done; t++) begin
            @(posedge axis_clk);
            done = out_cnt >= num_samples;
        end
        if (!done) begin
            timeout_errs++;
            $display("timeout: only %0d of %0d output beats arrived", out_cnt, num_samples);
        end
    endtask

    // one full run on coef_h / samp_x followed by the done to idle status reads
    task automatic run_filter(input bit stall, input bit poke_busy);
        @(posedge axis_clk);
        exp_y   = fir_reference(coef_h, samp_x);
        out_cnt = 0;
        ready_random <= stall;
        bus_write(`FIR_REG_CTRL, 32'h1);   // ap_start
        if (poke_busy)
            bus_write(tap_addr(0), ~coef_h[0]);   // dropped since the engine is busy
        check_read(`FIR_REG_CTRL, status_busy, "control word before the first sample");
        send_samples(samp_x);
        wait_outputs();
        check_read(`FIR_REG_CTRL, status_done, "control word after run");
        check_read(`FIR_REG_CTRL, status_idle, "control word after done read");
    endtask

    initial begin
        axis_rst_n   = 1'b0;
        bus_req      = '0;
        ss_in        = '0;
        sm_tready    = 1'b0;
        ready_random = 1'b0;
        rng_state    = rng_seed;
        sink_rng     = xorshift32(rng_seed);
        out_cnt      = 0;
        value_errs   = 0;
        proto_errs   = 0;
        timeout_errs = 0;
        prev_stall   = 1'b0;
        prev_beat    = '0;
        repeat (5) @(posedge axis_clk);
        axis_rst_n <= 1'b1;

        // register access while idle
        check_read(`FIR_REG_CTRL, status_idle, "control word after reset");
        load_coefs();
        for (int i = 0; i < `FIR_NUM_TAPS; i++)
            check_read(tap_addr(i), coef_h[i], "coefficient readback");
        bus_write(`FIR_REG_LEN, 32'(num_samples));
        check_read(`FIR_REG_LEN, 32'(num_samples), "data length readback");
        for (int n = 0; n < num_samples; n++)
            samp_x[n] = next_random();

        run_filter(1'b0, 1'b0);   // free-flowing sink
        run_filter(1'b1, 1'b1);   // same data under stalls with a busy coef write
        check_read(tap_addr(0), coef_h[0], "coefficient 0 after busy write");

        // fresh coefs and samples on a history that starts from zero
        load_coefs();
        for (int n = 0; n < num_samples; n++)
            samp_x[n] = next_random();
        run_filter(1'b1, 1'b0);

        $display("errors: %0d value, %0d protocol, %0d timeout",
                 value_errs, proto_errs, timeout_errs);
        if (value_errs + proto_errs + timeout_errs == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: source/fir_top.sv
`timescale 1ns/100ps
`default_nettype none

module fir_top (
    input  logic                        axis_clk,
    input  logic                        axis_rst_n,
    input  fir_bus_pkg::bus_req_t       bus_req,
    output fir_bus_pkg::bus_rsp_t       bus_rsp,
    input  fir_types_pkg::stream_beat_t ss_in,
    output logic                        ss_tready,
    output fir_types_pkg::stream_beat_t sm_out,
    input  logic                        sm_tready
);
    import fir_types_pkg::*;

    // regs <-> coef bank
    logic     coef_wr_en;
    tap_idx_t coef_wr_idx, coef_rd_idx;
    coef_t    coef_wr_data, coef_rd_data;
    // run control
    logic     run_start, run_done, out_busy;
    len_t     data_length;
    // engine
    logic     sample_push;
    sample_t  push_data, tap_sample;
    tap_idx_t tap_idx;
    coef_t    tap_coef;
    mac_ctl_t mac_ctl;

    fir_regs regs_i (
        .axis_clk, .axis_rst_n, .bus_req, .bus_rsp,
        .coef_wr_en, .coef_wr_idx, .coef_rd_idx, .coef_wr_data, .coef_rd_data,
        .ss_ready_stat(ss_tready), .sm_valid_stat(sm_out.tvalid), .run_done,
        .run_start, .data_length
    );

    fir_coef_bank coef_i (
        .axis_clk, .axis_rst_n,
        .wr_en(coef_wr_en), .wr_idx(coef_wr_idx), .wr_data(coef_wr_data),
        .bus_idx(coef_rd_idx), .bus_data(coef_rd_data),
        .tap_idx, .tap_coef
    );

    fir_sample_buffer hist_i (
        .axis_clk, .axis_rst_n, .clear(run_start),
        .push(sample_push), .push_data, .tap_idx, .tap_sample
    );

    fir_tap_sequencer seq_i (
        .axis_clk, .axis_rst_n, .run_start, .data_length,
        .ss_in, .ss_tready, .out_busy, .sample_push, .push_data, .tap_idx, .mac_ctl
    );

    fir_mac mac_i (
        .axis_clk, .axis_rst_n, .mac_ctl, .tap_coef, .tap_sample,
        .sm_out, .sm_tready, .out_busy, .run_done
    );

endmodule

`default_nettype wire

// File: source/fir_mac.sv
`timescale 1ns/100ps
`default_nettype none

module fir_mac (
    input  logic                        axis_clk,
    input  logic                        axis_rst_n,
    input  fir_types_pkg::mac_ctl_t     mac_ctl,
    input  fir_types_pkg::coef_t        tap_coef,
    input  fir_types_pkg::sample_t      tap_sample,
    output fir_types_pkg::stream_beat_t sm_out,
    input  logic                        sm_tready,
    output logic                        out_busy,
    output logic                        run_done
);
    import fir_types_pkg::*;

    mac_ctl_t ctl_d1, ctl_d2, ctl_d3;  // read data, product, sum stages
    acc_t     prod_q, acc_q, out_data_q;
    logic     acc_last_q;              // tlast of the sum in acc_q
    logic     pend_q;                  // finished sum waiting for the output reg
    logic     out_valid_q, out_last_q;
    logic     sum_rdy, can_load;

    assign sum_rdy  = (ctl_d3.step && ctl_d3.final_tap) || pend_q;
    assign can_load = !out_valid_q || sm_tready;   // empty, or draining this edge

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            ctl_d1      <= '0;
            ctl_d2      <= '0;
            ctl_d3      <= '0;
            pend_q      <= 1'b0;
            out_valid_q <= 1'b0;
            out_last_q  <= 1'b0;
        end else begin
            ctl_d1 <= mac_ctl;
            ctl_d2 <= ctl_d1;
            ctl_d3 <= ctl_d2;
            pend_q <= sum_rdy && !can_load;
            if (sum_rdy && can_load) begin
                out_valid_q <= 1'b1;
                out_last_q  <= acc_last_q;
            end else if (sm_tready) begin
                out_valid_q <= 1'b0;
                out_last_q  <= 1'b0;
            end
        end
    end

    always_ff @(posedge axis_clk) begin
        prod_q <= tap_coef * tap_sample;            // low 32 bits only
        if (ctl_d2.step) begin
            acc_q      <= ctl_d2.first_tap ? prod_q : acc_q + prod_q;
            acc_last_q <= ctl_d2.last_out;
        end
        if (sum_rdy && can_load)
            out_data_q <= acc_q;
    end

    assign sm_out   = '{tvalid: out_valid_q, tdata: out_data_q, tlast: out_last_q};
    assign out_busy = out_valid_q || pend_q;
    assign run_done = out_valid_q && sm_tready && out_last_q;  // final beat leaves

    a_hold_stalled: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
        out_valid_q && !sm_tready |=> out_valid_q && $stable(out_data_q) && $stable(out_last_q))
        else $error("output beat changed while stalled");

endmodule

`default_nettype wire

// File: source/fir_tap_sequencer.sv
`timescale 1ns/100ps
`default_nettype none

`include "fir_params.svh"

module fir_tap_sequencer (
    input  logic                        axis_clk,
    input  logic                        axis_rst_n,
    input  logic                        run_start,
    input  fir_types_pkg::len_t         data_length,
    input  fir_types_pkg::stream_beat_t ss_in,
    output logic                        ss_tready,
    input  logic                        out_busy,
    output logic                        sample_push,
    output fir_types_pkg::sample_t      push_data,
    output fir_types_pkg::tap_idx_t     tap_idx,
    output fir_types_pkg::mac_ctl_t     mac_ctl
);
    import fir_types_pkg::*;

    localparam tap_idx_t last_tap = tap_idx_t'(`FIR_NUM_TAPS - 1);

    logic     active_q;    // run open, more samples expected
    logic     stepping_q;  // walking the taps of one sample
    logic     last_q;      // current sample is the final one
    tap_idx_t tap_q;
    len_t     in_cnt_q;    // samples accepted so far
    len_t     in_cnt_nxt;
    logic     accept;

    // no new sample while stepping or while the output side is full
    assign ss_tready   = active_q && !stepping_q && !out_busy;
    assign accept      = ss_in.tvalid && ss_tready;  // input tlast is ignored
    assign sample_push = accept;
    assign push_data   = ss_in.tdata;
    assign in_cnt_nxt  = in_cnt_q + len_t'(1);

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            active_q   <= 1'b0;
            stepping_q <= 1'b0;
            last_q     <= 1'b0;
            tap_q      <= '0;
            in_cnt_q   <= '0;
        end else if (run_start) begin
            active_q   <= 1'b1;
            stepping_q <= 1'b0;
            last_q     <= 1'b0;
            tap_q      <= '0;
            in_cnt_q   <= '0;
        end else if (accept) begin
            stepping_q <= 1'b1;
            tap_q      <= '0;         // tap 0 in the cycle after the accept edge
            in_cnt_q   <= in_cnt_nxt;
            last_q     <= in_cnt_nxt == data_length;
            if (in_cnt_nxt == data_length)
                active_q <= 1'b0;     // stop taking samples
        end else if (stepping_q) begin
            if (tap_q == last_tap) begin
                stepping_q <= 1'b0;
                tap_q      <= '0;
            end else begin
                tap_q <= tap_q + tap_idx_t'(1);
            end
        end
    end

    assign tap_idx = tap_q;  // shared by coef bank and sample buffer

    always_comb begin
        mac_ctl.step      = stepping_q;
        mac_ctl.first_tap = stepping_q && tap_q == '0;
        mac_ctl.final_tap = stepping_q && tap_q == last_tap;
        mac_ctl.last_out  = stepping_q && last_q;
    end

endmodule

`default_nettype wire

// File: source/fir_sample_buffer.sv
`timescale 1ns/100ps
`default_nettype none

`include "fir_params.svh"

module fir_sample_buffer (
    input  logic                    axis_clk,
    input  logic                    axis_rst_n,
    input  logic                    clear,
    input  logic                    push,
    input  fir_types_pkg::sample_t  push_data,
    input  fir_types_pkg::tap_idx_t tap_idx,
    output fir_types_pkg::sample_t  tap_sample
);
    import fir_types_pkg::*;

    localparam tap_idx_t last_slot = tap_idx_t'(`FIR_NUM_TAPS - 1);

    sample_t  hist_q [`FIR_NUM_TAPS];  // x[n-10] .. x[n], circular
    tap_idx_t head_q;                  // next slot to write
    logic [4:0] rd_sum;                // head - 1 - tap_idx, before the wrap
    tap_idx_t rd_ptr;

    // newest sample sits one slot behind head
    assign rd_sum = {1'b0, head_q} + 5'(`FIR_NUM_TAPS - 1) - {1'b0, tap_idx};
    assign rd_ptr = (rd_sum >= 5'(`FIR_NUM_TAPS)) ? tap_idx_t'(rd_sum - 5'(`FIR_NUM_TAPS))
                                                   : tap_idx_t'(rd_sum);

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            head_q <= '0;
            for (int i = 0; i < `FIR_NUM_TAPS; i++)
                hist_q[i] <= '0;
        end else if (clear) begin
            // new run, history counts as zero
            head_q <= '0;
            for (int i = 0; i < `FIR_NUM_TAPS; i++)
                hist_q[i] <= '0;
        end else if (push) begin
            hist_q[head_q] <= push_data;
            head_q         <= (head_q == last_slot) ? '0 : head_q + tap_idx_t'(1);
        end
    end

    // one cycle read, a same-cycle push wins for tap 0
    always_ff @(posedge axis_clk) begin
        if (push && tap_idx == '0)
            tap_sample <= push_data;
        else
            tap_sample <= hist_q[rd_ptr];
    end

endmodule

`default_nettype wire

// File: source/fir_coef_bank.sv
`timescale 1ns/100ps
`default_nettype none

`include "fir_params.svh"

module fir_coef_bank (
    input  logic                    axis_clk,
    input  logic                    axis_rst_n,
    input  logic                    wr_en,
    input  fir_types_pkg::tap_idx_t wr_idx,
    input  fir_types_pkg::coef_t    wr_data,
    input  fir_types_pkg::tap_idx_t bus_idx,
    output fir_types_pkg::coef_t    bus_data,
    input  fir_types_pkg::tap_idx_t tap_idx,
    output fir_types_pkg::coef_t    tap_coef
);
    import fir_types_pkg::*;

    coef_t coef_q [`FIR_NUM_TAPS];   // h[0..10], zero after reset

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            for (int i = 0; i < `FIR_NUM_TAPS; i++)
                coef_q[i] <= '0;
        end else if (wr_en) begin
            coef_q[wr_idx] <= wr_data;
        end
    end

    // two registered read ports: host readback and engine
    always_ff @(posedge axis_clk) begin
        bus_data <= coef_q[bus_idx];
        tap_coef <= coef_q[tap_idx];   // lines up with the sample buffer read
    end

    a_idx_range: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
        (!wr_en || wr_idx < `FIR_NUM_TAPS) && bus_idx < `FIR_NUM_TAPS &&
        tap_idx < `FIR_NUM_TAPS)
        else $error("coefficient index out of range");

endmodule

`default_nettype wire

// File: source/fir_regs.sv
`timescale 1ns/100ps
`default_nettype none

`include "fir_params.svh"

module fir_regs (
    input  logic                    axis_clk,
    input  logic                    axis_rst_n,
    input  fir_bus_pkg::bus_req_t   bus_req,
    output fir_bus_pkg::bus_rsp_t   bus_rsp,
    output logic                    coef_wr_en,
    output fir_types_pkg::tap_idx_t coef_wr_idx,
    output fir_types_pkg::tap_idx_t coef_rd_idx,
    output fir_types_pkg::coef_t    coef_wr_data,
    input  fir_types_pkg::coef_t    coef_rd_data,
    input  logic                    ss_ready_stat,
    input  logic                    sm_valid_stat,
    input  logic                    run_done,
    output logic                    run_start,
    output fir_types_pkg::len_t     data_length
);
    import fir_types_pkg::*;
    import fir_bus_pkg::*;

    typedef enum logic [1:0] {st_idle, st_busy, st_done} ap_state_t;

    ap_state_t              state_q;
    ctrl_status_t           status;
    logic [`FIR_ADDR_W-1:0] tap_off;     // offset into the tap window
    logic                   tap_hit;
    tap_idx_t               tap_idx;
    logic                   ctrl_hit, len_hit;
    logic                   rd_valid_q, rd_coef_q;
    logic [`FIR_DATA_W-1:0] rd_word_q;   // status or length snapshot
    len_t                   data_length_q;

    assign ctrl_hit = bus_req.addr == `FIR_REG_CTRL;
    assign len_hit  = bus_req.addr == `FIR_REG_LEN;
    assign tap_off  = bus_req.addr - `FIR_REG_TAP_BASE;
    assign tap_hit  = (bus_req.addr >= `FIR_REG_TAP_BASE) && (tap_off[1:0] == 2'b00) &&
                      (tap_off[`FIR_ADDR_W-1:2] < `FIR_NUM_TAPS);   // word aligned within h[0..10]
    assign tap_idx  = tap_off[5:2];

    // coefficient writes only land while idle
    assign coef_wr_en   = bus_req.wr_stb && tap_hit && (state_q == st_idle);
    assign coef_wr_idx  = tap_idx;
    assign coef_wr_data = bus_req.wdata;
    assign coef_rd_idx  = tap_hit ? tap_idx : '0;   // keep the bank index in range

    // start needs idle and a non-zero length
    assign run_start = bus_req.wr_stb && ctrl_hit && bus_req.wdata[0] &&
                       (state_q == st_idle) && (data_length_q != '0);
    assign data_length = data_length_q;

    always_comb begin
        status           = '0;
        status.ap_start  = state_q == st_busy;  // engine running
        status.ap_done   = state_q == st_done;
        status.ap_idle   = state_q == st_idle;
        status.ss_tready = ss_ready_stat;
        status.sm_tvalid = sm_valid_stat;
    end

    // idle -> busy -> done -> idle on a status read
    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            state_q       <= st_idle;
            data_length_q <= '0;
            rd_valid_q    <= 1'b0;
            rd_coef_q     <= 1'b0;
        end else begin
            case (state_q)
                st_idle: if (run_start) state_q <= st_busy;
                st_busy: if (run_done) state_q <= st_done;
                st_done: if (bus_req.rd_stb && ctrl_hit) state_q <= st_idle;
                default: state_q <= st_idle;
            endcase
            if (bus_req.wr_stb && len_hit && state_q == st_idle)
                data_length_q <= bus_req.wdata[`FIR_LEN_W-1:0];
            rd_valid_q <= bus_req.rd_stb;
            rd_coef_q  <= bus_req.rd_stb && tap_hit;   // bank data arrives next cycle
        end
    end

    // snapshot taken at the read edge so ap_done survives the move to idle
    always_ff @(posedge axis_clk) begin
        if (bus_req.rd_stb)
            rd_word_q <= ctrl_hit ? status :
                         len_hit  ? `FIR_DATA_W'(data_length_q) : '0;
    end

    always_comb begin
        bus_rsp.rd_valid = rd_valid_q;
        bus_rsp.rd_data  = rd_coef_q ? coef_rd_data : rd_word_q;
    end

    // both stream sides are quiet whenever a coef write lands
    a_coef_wr_idle: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
        coef_wr_en |-> !ss_ready_stat && !sm_valid_stat)
        else $error("coefficient write while the engine is active");

endmodule

`default_nettype wire

// File: source/fir_bus_pkg.sv
`default_nettype none

`include "fir_params.svh"

package fir_bus_pkg;

    // single-cycle strobe bus, no back-pressure
    typedef struct packed {
        logic                   wr_stb;
        logic                   rd_stb;
        logic [`FIR_ADDR_W-1:0] addr;
        logic [`FIR_DATA_W-1:0] wdata;
    } bus_req_t;

    // read data one cycle after rd_stb
    typedef struct packed {
        logic                   rd_valid;
        logic [`FIR_DATA_W-1:0] rd_data;
    } bus_rsp_t;

    // control word at FIR_REG_CTRL, bit 0 is the lsb
    typedef struct packed {
        logic [25:0] rsvd;      // reads zero
        logic        sm_tvalid; // bit 5
        logic        ss_tready; // bit 4
        logic        zero;      // bit 3
        logic        ap_idle;   // bit 2
        logic        ap_done;   // bit 1
        logic        ap_start;  // bit 0
    } ctrl_status_t;

endpackage

`default_nettype wire

// File: source/fir_types_pkg.sv
`default_nettype none

`include "fir_params.svh"

package fir_types_pkg;

    typedef logic [`FIR_DATA_W-1:0] sample_t;  // x[n]
    typedef logic [`FIR_DATA_W-1:0] coef_t;    // h[i]
    typedef logic [`FIR_DATA_W-1:0] acc_t;     // running sum, wraps mod 2^32
    typedef logic [3:0]             tap_idx_t; // 0 .. 10
    typedef logic [`FIR_LEN_W-1:0]  len_t;

    // one AXI-Stream beat, tready travels separately
    typedef struct packed {
        logic                   tvalid;
        logic [`FIR_DATA_W-1:0] tdata;
        logic                   tlast;
    } stream_beat_t;

    // per-step control, sequencer to MAC
    typedef struct packed {
        logic step;      // tap read issued this cycle
        logic first_tap; // restart the sum
        logic final_tap; // sum complete after this one
        logic last_out;  // this output closes the run
    } mac_ctl_t;

endpackage

`default_nettype wire

// File: source/fir_params.svh
`ifndef FIR_PARAMS_SVH
`define FIR_PARAMS_SVH

// filter geometry
`define FIR_NUM_TAPS     11   // h[0] .. h[10]

// datapath and bus widths
`define FIR_DATA_W       32   // samples, coefs, bus data
`define FIR_ADDR_W       12   // byte address on the register bus
`define FIR_LEN_W        16   // samples per run

// register map, byte offsets
`define FIR_REG_CTRL     12'h000  // control / status word
`define FIR_REG_LEN      12'h010  // data length
`define FIR_REG_TAP_BASE 12'h080  // h[i] at base + 4*i

`endif
